/* Bender.yml */
package:
  name: riscv_top

sources:
  - rvIsaPkg.sv
  - rvPipePkg.sv
  - stageCtrlIf.sv
  - instrDecode.sv
  - forwardUnit.sv
  - executeStage.sv
  - riscvTop.sv
  - target: simulation
    files:
      - tbRiscvTop.sv

/* executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   stageCtrlIf.consumer           ctrl,
   input  wire rvIsaPkg::wordT    pc,
   input  wire rvIsaPkg::wordT    rd1,
   input  wire rvIsaPkg::wordT    rd2,
   input  wire rvIsaPkg::wordT    imm,
   input  wire rvIsaPkg::wordT    memAlu,
   input  wire rvIsaPkg::wordT    memLoadData,
   input  wire rvIsaPkg::wordT    wbData,
   input  wire rvPipePkg::fwdSelE fwdA,
   input  wire rvPipePkg::fwdSelE fwdB,
   output rvIsaPkg::wordT         aluResult,
   output rvIsaPkg::wordT         storeData
);
   import rvIsaPkg::*;
   import rvPipePkg::*;

   wordT       opA;
   wordT       opB;
   wordT       aluA;
   wordT       aluB;
   logic [4:0] shamt;

   function automatic wordT forwardMux(
      wordT   regVal,
      fwdSelE sel,
      wordT   fromMem,
      wordT   fromLoad,
      wordT   fromWb
   );
      wordT res;
      case (sel)
         fwdFromMem:     res = fromMem;
         fwdFromMemLoad: res = fromLoad;
         fwdFromWb:      res = fromWb;
         default:        res = regVal;
      endcase
      return res;
   endfunction

   // register operands with forwarding applied
   assign opA = forwardMux(rd1, fwdA, memAlu, memLoadData, wbData);
   assign opB = forwardMux(rd2, fwdB, memAlu, memLoadData, wbData);

   assign aluA = (ctrl.srcA == srcAPc) ? pc : opA;
   assign aluB = (ctrl.srcB == srcBImm) ? imm : opB;

   assign shamt = aluB[4:0];

   // store data must see the newest rs2 as well
   assign storeData = opB;

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:   aluResult = aluA + aluB;
         aluSub:   aluResult = aluA - aluB;
         aluSll:   aluResult = aluA << shamt;
         aluSlt:   aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
         aluSltu:  aluResult = {31'b0, aluA < aluB};
         aluXor:   aluResult = aluA ^ aluB;
         aluSrl:   aluResult = aluA >> shamt;
         aluSra:   aluResult = wordT'($signed(aluA) >>> shamt);
         aluOr:    aluResult = aluA | aluB;
         aluAnd:   aluResult = aluA & aluB;
         aluPassB: aluResult = aluB;
         default:  aluResult = aluA + aluB;
      endcase
   end

endmodule

`default_nettype wire

/* forwardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
   input  wire rvIsaPkg::regAddrT rs1,
   input  wire rvIsaPkg::regAddrT rs2,
   input  wire rvIsaPkg::regAddrT memRd,
   input  wire rvIsaPkg::regAddrT wbRd,
   input  wire                    memRfWe,
   input  wire                    memIsLoad,
   input  wire                    wbRfWe,
   output rvPipePkg::fwdSelE      fwdA,
   output rvPipePkg::fwdSelE      fwdB
);
   import rvIsaPkg::*;
   import rvPipePkg::*;

   function automatic fwdSelE pickSource(regAddrT rs);
      fwdSelE sel;
      sel = fwdNone;
      // x0 reads zero whatever is in flight
      if (rs != '0) begin
         // memory stage is newer, so it wins
         if (memRfWe && (memRd == rs)) begin
            sel = memIsLoad ? fwdFromMemLoad : fwdFromMem;
         end else if (wbRfWe && (wbRd == rs)) begin
            sel = fwdFromWb;
         end
      end
      return sel;
   endfunction

   assign fwdA = pickSource(rs1);
   assign fwdB = pickSource(rs2);

   always_comb begin
      assert final (fwdA inside {fwdNone, fwdFromMem, fwdFromMemLoad, fwdFromWb} &&
                    fwdB inside {fwdNone, fwdFromMem, fwdFromMemLoad, fwdFromWb})
         else $error("illegal forwarding select");
   end

endmodule

`default_nettype wire

/* instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
   input  wire                    CLK,
   input  wire                    RSTn,
   input  wire rvIsaPkg::instrT   instr,
   input  wire rvIsaPkg::wordT    pc,
   input  wire                    fetchValid,
   output rvIsaPkg::regAddrT      rs1,
   output rvIsaPkg::regAddrT      rs2,
   output rvIsaPkg::wordT         imm,
   stageCtrlIf.producer           ctrl
);
   import rvIsaPkg::*;
   import rvPipePkg::*;

   opcodeT     opcode;
   logic [2:0] funct3;
   instrT      prevInstr;
   logic       haltPair;

   // funct3 plus the alternate bit picks the ALU function
   function automatic aluOpE aluFromFunct3(logic [2:0] f3, logic alt);
      aluOpE op;
      case (f3)
         3'b000:  op = alt ? aluSub : aluAdd;
         3'b001:  op = aluSll;
         3'b010:  op = aluSlt;
         3'b011:  op = aluSltu;
         3'b100:  op = aluXor;
         3'b101:  op = alt ? aluSra : aluSrl;
         3'b110:  op = aluOr;
         default: op = aluAnd;
      endcase
      return op;
   endfunction

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];

   // last fetched word, for halt pair detection
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         prevInstr <= '0;
      end else if (fetchValid) begin
         prevInstr <= instr;
      end
   end

   // nothing precedes the word at address zero
   assign haltPair = fetchValid && (pc != '0) &&
                     (prevInstr == HALT_FIRST) && (instr == HALT_SECOND);

   // immediate formats
   always_comb begin
      case (opcode)
         STORE:      imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         LUI, AUIPC: imm = {instr[31:12], 12'b0};
         default:    imm = {{20{instr[31]}}, instr[31:20]};
      endcase
   end

   always_comb begin
      ctrl.aluOp    = aluAdd;
      ctrl.srcA     = srcARs1;
      ctrl.srcB     = srcBImm;
      ctrl.wbSrc    = wbAlu;
      ctrl.memRead  = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.rfWe     = 1'b0;
      ctrl.halt     = 1'b0;
      ctrl.valid    = 1'b0;
      ctrl.rd       = instr[11:7];
      if (haltPair) begin
         // jalr x0 writes nothing, it only carries the halt
         ctrl.halt  = 1'b1;
         ctrl.valid = 1'b1;
      end else if (fetchValid) begin
         case (opcode)
            OP: begin
               ctrl.aluOp = aluFromFunct3(funct3, instr[30]);
               ctrl.srcB  = srcBRs2;
               ctrl.rfWe  = 1'b1;
               ctrl.valid = 1'b1;
            end
            OP_IMM: begin
               ctrl.aluOp = aluFromFunct3(funct3, (funct3 == F3_SHIFT_RIGHT) && instr[30]);
               ctrl.rfWe  = 1'b1;
               ctrl.valid = 1'b1;
            end
            LUI: begin
               ctrl.aluOp = aluPassB;
               ctrl.rfWe  = 1'b1;
               ctrl.valid = 1'b1;
            end
            AUIPC: begin
               ctrl.srcA  = srcAPc;
               ctrl.rfWe  = 1'b1;
               ctrl.valid = 1'b1;
            end
            LOAD: begin
               ctrl.memRead = (funct3 == F3_WORD);
               ctrl.wbSrc   = wbMem;
               ctrl.rfWe    = (funct3 == F3_WORD);
               ctrl.valid   = (funct3 == F3_WORD);
            end
            STORE: begin
               ctrl.memWrite = (funct3 == F3_WORD);
               ctrl.valid    = (funct3 == F3_WORD);
            end
            default: begin
               // unsupported opcode, leave a bubble
               ctrl.valid = 1'b0;
            end
         endcase
      end
   end

   // stores never write the register file
   assert property (@(posedge CLK) disable iff (RSTn) !(ctrl.rfWe && ctrl.memWrite));

endmodule

`default_nettype wire

/* project.f */
rvIsaPkg.sv
rvPipePkg.sv
stageCtrlIf.sv
instrDecode.sv
forwardUnit.sv
executeStage.sv
riscvTop.sv
tbRiscvTop.sv

/* riscvTop.sv */
`timescale 1ns/1ps
`default_nettype none

module riscvTop (
   input  wire                    CLK,
   input  wire                    RSTn,

   output logic                   I_MEM_CSN,
   input  wire rvIsaPkg::instrT   I_MEM_DI,
   output rvIsaPkg::memAddrT      I_MEM_ADDR,

   output logic                   D_MEM_CSN,
   input  wire rvIsaPkg::wordT    D_MEM_DI,
   output rvIsaPkg::wordT         D_MEM_DOUT,
   output rvIsaPkg::memAddrT      D_MEM_ADDR,
   output logic                   D_MEM_WEN,
   output logic [3:0]             D_MEM_BE,

   output logic                   RF_WE,
   output rvIsaPkg::regAddrT      RF_RA1,
   output rvIsaPkg::regAddrT      RF_RA2,
   output rvIsaPkg::regAddrT      RF_WA1,
   input  wire rvIsaPkg::wordT    RF_RD1,
   input  wire rvIsaPkg::wordT    RF_RD2,
   output rvIsaPkg::wordT         RF_WD,

   output logic                   HALT,
   output rvIsaPkg::wordT         NUM_INST,
   output rvIsaPkg::wordT         OUTPUT_PORT
);
   import rvIsaPkg::*;
   import rvPipePkg::*;

   stageCtrlIf idCtrl ();
   stageCtrlIf exCtrl ();

   // fetch and decode
   wordT     pc;
   logic     fetchStop;
   logic     fetchValid;
   wordT     idImm;
   ctrlWordT idWord;

   // execute
   ctrlWordT exWord;
   wordT     exPc;
   wordT     exRd1;
   wordT     exRd2;
   wordT     exImm;
   regAddrT  exRs1;
   regAddrT  exRs2;
   fwdSelE   fwdA;
   fwdSelE   fwdB;
   wordT     aluResult;
   wordT     storeData;

   // memory and writeback
   ctrlWordT memWord;
   wordT     memAlu;
   wordT     memStore;
   ctrlWordT wbWord;
   wordT     wbAlu;
   wordT     wbLoad;

   assign fetchValid = !fetchStop;
   assign I_MEM_ADDR = pc[11:0];
   assign I_MEM_CSN  = fetchStop;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc        <= '0;
         fetchStop <= 1'b0;
      end else begin
         if (fetchValid) begin
            pc <= pc + 32'd4;
         end
         // halt pair decoded, nothing more gets fetched
         if (idCtrl.valid && idCtrl.halt) begin
            fetchStop <= 1'b1;
         end
      end
   end

   instrDecode decoder (
      .CLK        (CLK),
      .RSTn       (RSTn),
      .instr      (I_MEM_DI),
      .pc         (pc),
      .fetchValid (fetchValid),
      .rs1        (RF_RA1),
      .rs2        (RF_RA2),
      .imm        (idImm),
      .ctrl       (idCtrl)
   );

   assign idWord = '{aluOp: idCtrl.aluOp, srcA: idCtrl.srcA, srcB: idCtrl.srcB,
                     wbSrc: idCtrl.wbSrc, memRead: idCtrl.memRead,
                     memWrite: idCtrl.memWrite, rfWe: idCtrl.rfWe, halt: idCtrl.halt,
                     valid: idCtrl.valid, rd: idCtrl.rd};

   // control moves one stage per cycle
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         exWord  <= '0;
         memWord <= '0;
         wbWord  <= '0;
      end else begin
         exWord  <= idWord;
         memWord <= exWord;
         wbWord  <= memWord;
      end
   end

   always_ff @(posedge CLK) begin
      exPc     <= pc;
      exRd1    <= RF_RD1;
      exRd2    <= RF_RD2;
      exImm    <= idImm;
      exRs1    <= RF_RA1;
      exRs2    <= RF_RA2;
      memAlu   <= aluResult;
      memStore <= storeData;
      wbAlu    <= memAlu;
      wbLoad   <= D_MEM_DI;
   end

   assign exCtrl.aluOp    = exWord.aluOp;
   assign exCtrl.srcA     = exWord.srcA;
   assign exCtrl.srcB     = exWord.srcB;
   assign exCtrl.wbSrc    = exWord.wbSrc;
   assign exCtrl.memRead  = exWord.memRead;
   assign exCtrl.memWrite = exWord.memWrite;
   assign exCtrl.rfWe     = exWord.rfWe;
   assign exCtrl.halt     = exWord.halt;
   assign exCtrl.valid    = exWord.valid;
   assign exCtrl.rd       = exWord.rd;

   forwardUnit forwarder (
      .rs1       (exRs1),
      .rs2       (exRs2),
      .memRd     (memWord.rd),
      .wbRd      (wbWord.rd),
      .memRfWe   (memWord.valid && memWord.rfWe),
      .memIsLoad (memWord.memRead),
      .wbRfWe    (RF_WE),
      .fwdA      (fwdA),
      .fwdB      (fwdB)
   );

   // a load's data comes straight off the D-mem read port
   executeStage execUnit (
      .ctrl        (exCtrl),
      .pc          (exPc),
      .rd1         (exRd1),
      .rd2         (exRd2),
      .imm         (exImm),
      .memAlu      (memAlu),
      .memLoadData (D_MEM_DI),
      .wbData      (RF_WD),
      .fwdA        (fwdA),
      .fwdB        (fwdB),
      .aluResult   (aluResult),
      .storeData   (storeData)
   );

   // word address for the data memory
   assign D_MEM_ADDR = memAlu[13:2];
   assign D_MEM_DOUT = memStore;
   assign D_MEM_BE   = 4'b1111;
   assign D_MEM_WEN  = !(memWord.valid && memWord.memWrite);
   assign D_MEM_CSN  = !(memWord.valid && (memWord.memRead || memWord.memWrite));

   assign RF_WE       = wbWord.valid && wbWord.rfWe;
   assign RF_WA1      = wbWord.rd;
   assign RF_WD       = (wbWord.wbSrc == wbMem) ? wbLoad : wbAlu;
   assign OUTPUT_PORT = RF_WE ? RF_WD : wbAlu;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         NUM_INST <= '0;
         HALT     <= 1'b0;
      end else begin
         if (wbWord.valid) begin
            NUM_INST <= NUM_INST + 32'd1;
         end
         // rises as the halt word enters writeback
         if (memWord.valid && memWord.halt) begin
            HALT <= 1'b1;
         end
      end
   end

   assert property (@(posedge CLK) disable iff (RSTn) HALT |=> HALT);

   // once halted, fetch stop has drained every later write
   assert property (@(posedge CLK) disable iff (RSTn) HALT |-> !RF_WE && D_MEM_WEN);

endmodule

`default_nettype wire

/* rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

   // data and instruction words
   typedef logic [31:0] wordT;
   typedef logic [31:0] instrT;

   // register index and memory port address
   typedef logic [4:0]  regAddrT;
   typedef logic [11:0] memAddrT;

   typedef logic [6:0]  opcodeT;

   // major opcodes the core executes
   localparam opcodeT OP     = 7'b0110011;
   localparam opcodeT OP_IMM = 7'b0010011;
   localparam opcodeT LUI    = 7'b0110111;
   localparam opcodeT AUIPC  = 7'b0010111;
   localparam opcodeT LOAD   = 7'b0000011;
   localparam opcodeT STORE  = 7'b0100011;

   // funct3 of word-sized loads and stores
   localparam logic [2:0] F3_WORD = 3'b010;

   // funct3 shared by srl/sra and srli/srai
   localparam logic [2:0] F3_SHIFT_RIGHT = 3'b101;

   // halt pair, addi x1,x0,12 followed by jalr x0,0(x1)
   localparam instrT HALT_FIRST  = 32'h00c00093;
   localparam instrT HALT_SECOND = 32'h00008067;

endpackage

`default_nettype wire

/* rvPipePkg.sv */
`default_nettype none

package rvPipePkg;

   // ALU functions, passB serves LUI
   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluSll,
      aluSlt,
      aluSltu,
      aluXor,
      aluSrl,
      aluSra,
      aluOr,
      aluAnd,
      aluPassB
   } aluOpE;

   typedef enum logic {srcARs1, srcAPc} srcAE;
   typedef enum logic {srcBRs2, srcBImm} srcBE;
   typedef enum logic {wbAlu, wbMem} wbSrcE;

   // operand source in execute
   typedef enum logic [1:0] {fwdNone, fwdFromMem, fwdFromMemLoad, fwdFromWb} fwdSelE;

   // one instruction's control as held in a pipeline register
   typedef struct packed {
      aluOpE             aluOp;
      srcAE              srcA;
      srcBE              srcB;
      wbSrcE             wbSrc;
      logic              memRead;
      logic              memWrite;
      logic              rfWe;
      logic              halt;
      logic              valid;
      rvIsaPkg::regAddrT rd;
   } ctrlWordT;

endpackage

`default_nettype wire

/* stageCtrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface stageCtrlIf;
   import rvIsaPkg::*;
   import rvPipePkg::*;

   // what execute needs
   aluOpE   aluOp;
   srcAE    srcA;
   srcBE    srcB;

   // carried on to memory and writeback
   wbSrcE   wbSrc;
   logic    memRead;
   logic    memWrite;
   logic    rfWe;
   logic    halt;
   logic    valid;
   regAddrT rd;

   modport producer (
      output aluOp, srcA, srcB, wbSrc,
      output memRead, memWrite, rfWe,
      output halt, valid, rd
   );

   modport consumer (
      input aluOp, srcA, srcB, wbSrc,
      input memRead, memWrite, rfWe,
      input halt, valid, rd
   );

endinterface

`default_nettype wire

/* tbRiscvTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRiscvTop;

   localparam int RESET_CYCLES     = 16;
   localparam int PROG_LEN         = 64;
   localparam int FILLER_LEN       = 4;
   localparam int NUM_TESTS        = 3;
   localparam int POST_HALT_CYCLES = 8;
   // every generated word including halt pair and fillers
   localparam int TOTAL_INSTR      = NUM_TESTS * (PROG_LEN + 2 + FILLER_LEN);
   localparam int CYCLE_LIMIT      = TOTAL_INSTR * 2 + 100;

   // scratch region for loads and stores as byte offset from x0
   localparam logic [11:0] MEM_BASE  = 12'h100;
   localparam int          MEM_SLOTS = 8;

   localparam logic [6:0] OPC_OP    = 7'b0110011;
   localparam logic [6:0] OPC_IMM   = 7'b0010011;
   localparam logic [6:0] OPC_LUI   = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC = 7'b0010111;
   localparam logic [6:0] OPC_LOAD  = 7'b0000011;
   localparam logic [6:0] OPC_STORE = 7'b0100011;
   localparam logic [6:0] OPC_JALR  = 7'b1100111;

   logic        CLK;
   logic        RSTn;
   logic        I_MEM_CSN;
   logic [31:0] I_MEM_DI;
   logic [11:0] I_MEM_ADDR;
   logic        D_MEM_CSN;
   logic [31:0] D_MEM_DI;
   logic [31:0] D_MEM_DOUT;
   logic [11:0] D_MEM_ADDR;
   logic        D_MEM_WEN;
   logic [3:0]  D_MEM_BE;
   logic        RF_WE;
   logic [4:0]  RF_RA1;
   logic [4:0]  RF_RA2;
   logic [4:0]  RF_WA1;
   logic [31:0] RF_RD1;
   logic [31:0] RF_RD2;
   logic [31:0] RF_WD;
   logic        HALT;
   logic [31:0] NUM_INST;
   logic [31:0] OUTPUT_PORT;

   // memories and register file seen by the DUT
   logic [31:0] imem [0:1023];
   logic [31:0] dmem [0:4095];
   logic [31:0] rf [0:31];

   // reference state advanced one instruction at a time
   logic [31:0] refRegs [0:31];
   logic [31:0] refMem [0:4095];

   logic [4:0]  expWa [$];
   logic [31:0] expWd [$];
   logic [11:0] expSa [$];
   logic [31:0] expSd [$];

   string       testName   = "startup";
   int          errorCount = 0;
   int          failCount  = 0;
   int          cycleCount = 0;
   int          expRetired = 0;

   riscvTop dut_i (
      .CLK         (CLK),
      .RSTn        (RSTn),
      .I_MEM_CSN   (I_MEM_CSN),
      .I_MEM_DI    (I_MEM_DI),
      .I_MEM_ADDR  (I_MEM_ADDR),
      .D_MEM_CSN   (D_MEM_CSN),
      .D_MEM_DI    (D_MEM_DI),
      .D_MEM_DOUT  (D_MEM_DOUT),
      .D_MEM_ADDR  (D_MEM_ADDR),
      .D_MEM_WEN   (D_MEM_WEN),
      .D_MEM_BE    (D_MEM_BE),
      .RF_WE       (RF_WE),
      .RF_RA1      (RF_RA1),
      .RF_RA2      (RF_RA2),
      .RF_WA1      (RF_WA1),
      .RF_RD1      (RF_RD1),
      .RF_RD2      (RF_RD2),
      .RF_WD       (RF_WD),
      .HALT        (HALT),
      .NUM_INST    (NUM_INST),
      .OUTPUT_PORT (OUTPUT_PORT)
   );

   initial CLK = 1'b0;
   always #4 CLK = ~CLK;

   // combinational reads with byte-addressed fetch
   assign I_MEM_DI = imem[I_MEM_ADDR[11:2]];
   assign D_MEM_DI = dmem[D_MEM_ADDR];

   // write-first register file where x0 reads zero
   assign RF_RD1 = (RF_RA1 == 5'd0) ? 32'd0 :
                   ((RF_WE === 1'b1) && (RF_WA1 == RF_RA1)) ? RF_WD : rf[RF_RA1];
   assign RF_RD2 = (RF_RA2 == 5'd0) ? 32'd0 :
                   ((RF_WE === 1'b1) && (RF_WA1 == RF_RA2)) ? RF_WD : rf[RF_RA2];

   always @(posedge CLK) begin
      if ((RF_WE === 1'b1) && (RF_WA1 != 5'd0)) begin
         rf[RF_WA1] <= RF_WD;
      end
      if (D_MEM_WEN === 1'b0) begin
         dmem[D_MEM_ADDR] <= D_MEM_DOUT;
      end
   end

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         errorCount++;
         $display("[ERROR] test %s, %s: expected 0x%08h, actual 0x%08h",
                  testName, what, expected, actual);
      end
   endtask

   task automatic reportFailure(input string msg);
      failCount++;
      $display("test %s: %s", testName, msg);
   endtask

   // ISA arithmetic where alt selects sub and sra
   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
      logic [31:0] r;
      case (f3)
         3'd0:    r = alt ? a - b : a + b;
         3'd1:    r = a << b[4:0];
         3'd2:    r = {31'd0, $signed(a) < $signed(b)};
         3'd3:    r = {31'd0, a < b};
         3'd4:    r = a ^ b;
         3'd5: begin
            if (alt) begin
               r = $signed(a) >>> b[4:0];
            end else begin
               r = a >> b[4:0];
            end
         end
         3'd6:    r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [4:0] pickReg(input int pool);
      // small pools skip x0 so results chain
      if (pool >= 32) begin
         return $urandom_range(0, 31);
      end
      return 5'd1 + $urandom_range(0, pool - 1);
   endfunction

   function automatic logic [31:0] fillWord(input int a, input int t);
      return (a * 32'h9e3779b1) ^ {t[7:0], 24'h0} ^ 32'h5a5aa5a5;
   endfunction

   task automatic prepareModels(input int testIdx);
      for (int a = 0; a < 4096; a++) begin
         dmem[a]   = fillWord(a, testIdx);
         refMem[a] = fillWord(a, testIdx);
      end
      for (int a = 0; a < 1024; a++) begin
         imem[a] = 32'd0;
      end
      rf[0]      = 32'd0;
      refRegs[0] = 32'd0;
      for (int r = 1; r < 32; r++) begin
         rf[r]      = $urandom;
         refRegs[r] = rf[r];
      end
   endtask

   // writes the program and runs it through the reference model
   task automatic buildProgram(input int len, input int kindMax, input int pool);
      int          kind;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic        alt;
      logic [11:0] imm12;
      logic [19:0] imm20;
      logic [11:0] wordAddr;
      logic [31:0] word;
      logic [31:0] res;
      for (int i = 0; i < len; i++) begin
         kind  = $urandom_range(0, kindMax);
         rd    = pickReg(pool);
         rs1   = pickReg(pool);
         rs2   = pickReg(pool);
         f3    = $urandom_range(0, 7);
         alt   = 1'b0;
         imm12 = $urandom;
         imm20 = $urandom;
         imm12 = (kind >= 4) ? MEM_BASE + 12'($urandom_range(0, MEM_SLOTS - 1) * 4) : imm12;
         wordAddr = {2'b00, imm12[11:2]};
         case (kind)
            0: begin
               alt  = ((f3 == 3'd0) || (f3 == 3'd5)) ? $urandom_range(0, 1) : 1'b0;
               word = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, OPC_OP};
               res  = aluRef(f3, alt, refRegs[rs1], refRegs[rs2]);
            end
            1: begin
               if (f3 == 3'd1) begin
                  imm12 = {7'd0, imm12[4:0]};
               end else if (f3 == 3'd5) begin
                  alt   = $urandom_range(0, 1);
                  imm12 = {1'b0, alt, 5'd0, imm12[4:0]};
               end
               word = encI(imm12, rs1, f3, rd, OPC_IMM);
               res  = aluRef(f3, alt, refRegs[rs1], {{20{imm12[11]}}, imm12});
            end
            2: begin
               word = {imm20, rd, OPC_LUI};
               res  = {imm20, 12'd0};
            end
            3: begin
               word = {imm20, rd, OPC_AUIPC};
               res  = 32'(i * 4) + {imm20, 12'd0};
            end
            4: begin
               word = encI(imm12, 5'd0, 3'b010, rd, OPC_LOAD);
               res  = refMem[wordAddr];
            end
            default: begin
               word = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], OPC_STORE};
               refMem[wordAddr] = refRegs[rs2];
               expSa.push_back(wordAddr);
               expSd.push_back(refRegs[rs2]);
            end
         endcase
         imem[i] = word;
         if (kind <= 4) begin
            expWa.push_back(rd);
            expWd.push_back(res);
            if (rd != 5'd0) begin
               refRegs[rd] = res;
            end
         end
      end
      // halt pair addi x1,x0,12 then jalr x0,0(x1)
      imem[len]     = encI(12'd12, 5'd0, 3'b000, 5'd1, OPC_IMM);
      imem[len + 1] = encI(12'd0, 5'd1, 3'b000, 5'd0, OPC_JALR);
      expWa.push_back(5'd1);
      expWd.push_back(32'd12);
      for (int i = 0; i < FILLER_LEN; i++) begin
         imm12 = $urandom;
         imem[len + 2 + i] = encI(imm12, pickReg(pool), 3'b000, pickReg(pool), OPC_IMM);
      end
      expRetired = len + 2;
   endtask

   task automatic checkResetOutputs(input string when);
      checkValue({when, " HALT"}, 32'd0, HALT);
      checkValue({when, " RF_WE"}, 32'd0, RF_WE);
      checkValue({when, " D_MEM_WEN"}, 32'd1, D_MEM_WEN);
      checkValue({when, " D_MEM_CSN"}, 32'd1, D_MEM_CSN);
      checkValue({when, " I_MEM_CSN"}, 32'd0, I_MEM_CSN);
      checkValue({when, " NUM_INST"}, 32'd0, NUM_INST);
      checkValue({when, " I_MEM_ADDR"}, 32'd0, I_MEM_ADDR);
   endtask

   task automatic runProgram(input string name, input int testIdx, input int kindMax,
                             input int pool);
      testName = name;
      @(posedge CLK);
      #1;
      RSTn = 1'b1;
      expWa.delete();
      expWd.delete();
      expSa.delete();
      expSd.delete();
      prepareModels(testIdx);
      buildProgram(PROG_LEN, kindMax, pool);
      // the first negedge comes before any reset edge
      for (int c = 1; c <= RESET_CYCLES; c++) begin
         @(negedge CLK);
         if (c > 1) begin
            checkResetOutputs("during reset");
         end
      end
      @(posedge CLK);
      #1;
      RSTn = 1'b0;
      @(negedge CLK);
      checkResetOutputs("after reset");
      while (HALT !== 1'b1) begin
         @(negedge CLK);
      end
      repeat (POST_HALT_CYCLES) begin
         @(negedge CLK);
         checkValue("HALT held", 32'd1, HALT);
         checkValue("I_MEM_CSN after halt", 32'd1, I_MEM_CSN);
         checkValue("D_MEM_CSN after halt", 32'd1, D_MEM_CSN);
      end
      checkValue("NUM_INST", expRetired, NUM_INST);
      if (expWa.size() != 0) begin
         reportFailure($sformatf("%0d register writes never happened", expWa.size()));
      end
      if (expSa.size() != 0) begin
         reportFailure($sformatf("%0d stores never happened", expSa.size()));
      end
   endtask

   // write monitor
   always @(negedge CLK) begin
      if (RF_WE === 1'b1) begin
         if (expWa.size() == 0) begin
            reportFailure($sformatf("register write to x%0d when none was expected", RF_WA1));
         end else begin
            checkValue("write address", expWa[0], RF_WA1);
            checkValue("write data", expWd[0], RF_WD);
            checkValue("OUTPUT_PORT", expWd[0], OUTPUT_PORT);
            void'(expWa.pop_front());
            void'(expWd.pop_front());
         end
      end
   end

   // store monitor
   always @(negedge CLK) begin
      if (D_MEM_WEN === 1'b0) begin
         if (expSa.size() == 0) begin
            reportFailure($sformatf("store to word 0x%03h when none was expected", D_MEM_ADDR));
         end else begin
            checkValue("store address", expSa[0], D_MEM_ADDR);
            checkValue("store data", expSd[0], D_MEM_DOUT);
            checkValue("store byte enables", 32'hf, D_MEM_BE);
            checkValue("store chip select", 32'd0, D_MEM_CSN);
            void'(expSa.pop_front());
            void'(expSd.pop_front());
         end
      end
   end

   always @(posedge CLK) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CYCLE_LIMIT) begin
         $display("timeout: test %s did not reach HALT within %0d cycles",
                  testName, CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      RSTn = 1'b1;
      void'($urandom(32'h67271eca));
      runProgram("aluRandom", 0, 3, 32);
      runProgram("forwarding", 1, 3, 4);
      runProgram("loadStore", 2, 5, 4);
      $display("%0d value mismatches, %0d other failures", errorCount, failCount);
      if ((errorCount == 0) && (failCount == 0)) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
